// File: Makefile
# Verilator build and run of the pipeline core testbench.

VERILATOR ?= verilator
TOP       ?= tb_pipe_core
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= ALL TESTS PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "test: pass"; \
	else \
		echo "test: fail, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: common/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

    localparam int XLEN         = 32;
    localparam int IM_ADDR_NBIT = 8;  // the PC counts words.
    localparam int DM_ADDR_NBIT = 6;
    localparam int REG_NBIT     = 5;
    localparam int BHT_IDX_NBIT = 4;

    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_J     = 6'h02;
    localparam logic [5:0] OP_BEQ   = 6'h04;
    localparam logic [5:0] OP_BNE   = 6'h05;
    localparam logic [5:0] OP_ADDI  = 6'h08;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_SW    = 6'h2b;
    localparam logic [5:0] OP_HALT  = 6'h3f;

    localparam logic [5:0] FN_ADD = 6'h20;
    localparam logic [5:0] FN_SUB = 6'h22;
    localparam logic [5:0] FN_AND = 6'h24;
    localparam logic [5:0] FN_OR  = 6'h25;
    localparam logic [5:0] FN_SLT = 6'h2a;

    localparam logic [1:0] BHT_OP_NOP = 2'd0;
    localparam logic [1:0] BHT_OP_SET = 2'd1;  // counter goes to strongly taken.
    localparam logic [1:0] BHT_OP_INC = 2'd2;
    localparam logic [1:0] BHT_OP_DEC = 2'd3;

    localparam logic [1:0] FWD_NORM = 2'd0;  // operand from the register file.
    localparam logic [1:0] FWD_TMP  = 2'd1;  // operand from the EX result.
    localparam logic [1:0] FWD_DAT  = 2'd2;  // operand from the MA result.

    typedef union packed {
        struct packed {
            logic [5:0]          op;
            logic [REG_NBIT-1:0] rs;
            logic [REG_NBIT-1:0] rt;
            logic [REG_NBIT-1:0] rd;
            logic [4:0]          shamt;
            logic [5:0]          funct;
        } r_fmt;
        struct packed {
            logic [5:0]          op;
            logic [REG_NBIT-1:0] rs;
            logic [REG_NBIT-1:0] rt;
            logic signed [15:0]  imm16;
        } i_fmt;
        struct packed {
            logic [5:0]  op;
            logic [25:0] target26;
        } j_fmt;
    } instr_t;

endpackage

`default_nettype wire

// File: fetch/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit
    import pipe_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [XLEN-1:0]         imem_data,
    input  logic                    pc_en,
    input  logic                    redirect,
    input  logic [IM_ADDR_NBIT-1:0] redirect_pc,
    input  logic [1:0]              bht_op,
    input  logic [IM_ADDR_NBIT-1:0] bht_pc,
    input  logic                    ifid_en,
    input  logic                    ifid_nop,
    output logic [IM_ADDR_NBIT-1:0] imem_addr,
    output logic [IM_ADDR_NBIT-1:0] id_pc,
    output instr_t                  id_instr,
    output logic                    id_valid
);

    logic [IM_ADDR_NBIT-1:0] pc, pc_seq, pc_pred;
    logic [1:0]              bht [2**BHT_IDX_NBIT];
    logic [BHT_IDX_NBIT-1:0] upd_idx;
    logic [1:0]              upd_cnt;
    instr_t                  fetch_word;

    assign imem_addr  = pc;
    assign pc_seq     = pc + 1'b1;
    assign fetch_word = imem_data;
    assign upd_idx    = bht_pc[BHT_IDX_NBIT-1:0];
    assign upd_cnt    = bht[upd_idx];

    always_comb begin
        pc_pred = pc_seq;
        if (fetch_word.j_fmt.op == OP_J) begin
            pc_pred = fetch_word.j_fmt.target26[IM_ADDR_NBIT-1:0];
        end else if ((fetch_word.i_fmt.op == OP_BEQ || fetch_word.i_fmt.op == OP_BNE) &&
                     bht[pc[BHT_IDX_NBIT-1:0]][1]) begin  // counter of 2 or more.
            pc_pred = pc_seq + fetch_word.i_fmt.imm16[IM_ADDR_NBIT-1:0];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 2**BHT_IDX_NBIT; i++) begin
                bht[i] <= 2'd1;  // weakly not taken.
            end
        end else begin
            case (bht_op)
                BHT_OP_SET: bht[upd_idx] <= 2'd3;
                BHT_OP_INC: bht[upd_idx] <= (upd_cnt == 2'd3) ? upd_cnt : upd_cnt + 2'd1;
                BHT_OP_DEC: bht[upd_idx] <= (upd_cnt == 2'd0) ? upd_cnt : upd_cnt - 2'd1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc       <= '0;
            id_valid <= 1'b0;
        end else begin
            if (pc_en) begin
                pc <= redirect ? redirect_pc : pc_pred;
            end
            if (ifid_nop) begin
                id_valid <= 1'b0;
            end else if (ifid_en) begin
                id_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ifid_en) begin
            id_pc    <= pc;
            id_instr <= fetch_word;
        end
    end

    // predecode always follows j, so a resolved jump never needs recovery.
    assert property (@(posedge clk) disable iff (!rst_n) bht_op == BHT_OP_SET |-> !redirect)
        else $error("jump in EX caused a redirect");

endmodule

`default_nettype wire

// File: flist.f
common/pipe_pkg.sv
hazard/hazard_ctrl.sv
fetch/fetch_unit.sv
verilog/reg_file.sv
verilog/decode_stage.sv
verilog/exec_stage.sv
verilog/mem_stage.sv
verilog/pipe_core_top.sv
verification/tb_pipe_core.sv

// File: hazard/hazard_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module hazard_ctrl
    import pipe_pkg::*;
(
    input  logic [IM_ADDR_NBIT-1:0] id_pc,
    input  logic                    id_valid,
    input  logic                    id_rf_ra,
    input  logic                    id_rf_rb,
    input  logic [REG_NBIT-1:0]     id_rf_req_a,
    input  logic [REG_NBIT-1:0]     id_rf_req_b,
    input  logic                    ex_valid,
    input  logic [IM_ADDR_NBIT-1:0] ex_pc,
    input  logic                    ex_rf_we,
    input  logic [REG_NBIT-1:0]     ex_rf_req_w,
    input  logic                    ex_is_load,
    input  logic                    ex_is_jump,
    input  logic                    ex_is_branch,
    input  logic                    ex_taken,
    input  logic [IM_ADDR_NBIT-1:0] ex_target,
    input  logic                    ex_halt,
    input  logic                    ma_valid,
    input  logic                    ma_rf_we,
    input  logic [REG_NBIT-1:0]     ma_rf_req_w,
    input  logic                    wb_valid,
    output logic                    pc_en,
    output logic                    redirect,
    output logic [IM_ADDR_NBIT-1:0] redirect_pc,
    output logic [1:0]              bht_op,
    output logic [IM_ADDR_NBIT-1:0] bht_pc,
    output logic                    ifid_en,
    output logic                    ifid_nop,
    output logic                    idex_nop,
    output logic [1:0]              id_fwd_a,
    output logic [1:0]              id_fwd_b,
    output logic                    halted
);

    logic                    ex_wr, ma_wr;
    logic                    hit_a_ex, hit_a_ma, hit_b_ex, hit_b_ma;
    logic                    stall_a, stall_b;
    logic [IM_ADDR_NBIT-1:0] pc_correct;

    always_comb begin
        pc_en    = 1'b1;
        redirect = 1'b0;
        bht_op   = BHT_OP_NOP;
        ifid_en  = 1'b1;
        ifid_nop = 1'b0;
        idex_nop = 1'b0;
        id_fwd_a = FWD_NORM;
        id_fwd_b = FWD_NORM;

        ex_wr    = ex_valid && ex_rf_we && ex_rf_req_w != '0;  // r0 never conflicts.
        ma_wr    = ma_valid && ma_rf_we && ma_rf_req_w != '0;
        hit_a_ex = id_rf_ra && ex_wr && id_rf_req_a == ex_rf_req_w;
        hit_a_ma = id_rf_ra && ma_wr && id_rf_req_a == ma_rf_req_w;
        hit_b_ex = id_rf_rb && ex_wr && id_rf_req_b == ex_rf_req_w;
        hit_b_ma = id_rf_rb && ma_wr && id_rf_req_b == ma_rf_req_w;
        stall_a  = hit_a_ex && ex_is_load;  // load data is not ready until MA.
        stall_b  = hit_b_ex && ex_is_load;

        if (hit_a_ex && !ex_is_load) begin
            id_fwd_a = FWD_TMP;
        end else if (!hit_a_ex && hit_a_ma) begin
            id_fwd_a = FWD_DAT;
        end
        if (hit_b_ex && !ex_is_load) begin
            id_fwd_b = FWD_TMP;
        end else if (!hit_b_ex && hit_b_ma) begin
            id_fwd_b = FWD_DAT;
        end

        if (stall_a || stall_b || (ex_valid && ex_halt)) begin
            pc_en    = 1'b0;
            ifid_en  = 1'b0;
            idex_nop = 1'b1;
        end

        pc_correct = (ex_is_jump || (ex_is_branch && ex_taken)) ? ex_target : ex_pc + 1'b1;
        if (ex_valid && (!id_valid || id_pc != pc_correct)) begin
            redirect = 1'b1;  // the wrong path in IF/ID and ID/EX is dropped.
            pc_en    = 1'b1;
            ifid_en  = 1'b1;
            ifid_nop = 1'b1;
            idex_nop = 1'b1;
        end

        if (ex_valid && ex_is_jump) begin
            bht_op = BHT_OP_SET;
        end else if (ex_valid && ex_is_branch) begin
            bht_op = ex_taken ? BHT_OP_INC : BHT_OP_DEC;
        end
    end

    assign redirect_pc = pc_correct;
    assign bht_pc      = ex_pc;
    assign halted      = ex_valid && ex_halt && !ma_valid && !wb_valid;  // older writes drained.

endmodule

`default_nettype wire

// File: verification/core_trace.txt
# columns: P <word address hex> <instruction hex>, W <register decimal> <value hex>, C <cycles>
# W lines list the expected register writes in program order.
P 00 20010005  # addi r1, r0, 5
P 01 20220003  # addi r2, r1, 3
P 02 00221820  # add  r3, r1, r2
P 03 00612022  # sub  r4, r3, r1
P 04 00622824  # and  r5, r3, r2
P 05 00813025  # or   r6, r4, r1
P 06 0022382A  # slt  r7, r1, r2
P 07 AC060004  # sw   r6, 4(r0)
P 08 8C080004  # lw   r8, 4(r0)
P 09 01014820  # add  r9, r8, r1
P 0A 200A0000  # addi r10, r0, 0
P 0B 200B0003  # addi r11, r0, 3
P 0C 214A0001  # addi r10, r10, 1
P 0D 214C000A  # addi r12, r10, 10
P 0E 154BFFFD  # bne  r10, r11, back to 0C
P 0F 08000012  # j    12
P 10 200D0063  # addi r13, r0, 99 is jumped over
P 11 200E004D  # addi r14, r0, 77 is jumped over
P 12 10220003  # beq  r1, r2, to 16 is not taken
P 13 218F0001  # addi r15, r12, 1
P 14 00228022  # sub  r16, r1, r2
P 15 0200882A  # slt  r17, r16, r0
P 16 FC000000  # halt
W 1 00000005
W 2 00000008
W 3 0000000d
W 4 00000008
W 5 00000008
W 6 0000000d
W 7 00000001
W 8 0000000d
W 9 00000012
W 10 00000000
W 11 00000003
W 10 00000001
W 12 0000000b
W 10 00000002
W 12 0000000c
W 10 00000003
W 12 0000000d
W 15 0000000e
W 16 fffffffd
W 17 00000001
C 200

// File: verification/tb_pipe_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_pipe_core
    import pipe_pkg::*;
();

    localparam int    CLK_PERIOD   = 20;
    localparam int    RESET_CYCLES = 16;
    localparam int    HOLD_CYCLES  = 10;
    localparam int    HALT_PLANTS  = 8;
    localparam int    HIGH_NBIT    = IM_ADDR_NBIT - 1;
    localparam string TRACE_PATH   = "verification/core_trace.txt";

    logic                    clk;
    logic                    rst_n;
    logic [IM_ADDR_NBIT-1:0] imem_addr;
    logic [XLEN-1:0]         imem_data;
    logic                    wb_we;
    logic [REG_NBIT-1:0]     wb_reg;
    logic [XLEN-1:0]         wb_data;
    logic                    halted;

    logic [XLEN-1:0]     imem [2**IM_ADDR_NBIT];
    logic                prog_used [2**IM_ADDR_NBIT];
    logic [REG_NBIT-1:0] exp_reg [$];
    logic [XLEN-1:0]     exp_val [$];
    int                  exp_idx;
    int                  cycle_budget;

    pipe_core_top pipe_core_top_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .wb_we     (wb_we),
        .wb_reg    (wb_reg),
        .wb_data   (wb_data),
        .halted    (halted)
    );

    assign imem_data = imem[imem_addr];  // instruction memory answers within the cycle.

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic stop_on_failure();
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input logic [XLEN-1:0] actual, input logic [XLEN-1:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("** Error at %0t: %s is %h, expected %h", $time, what, actual, expected);
            stop_on_failure();
        end
    endtask

    task automatic fill_imem();
        for (int i = 0; i < 2**IM_ADDR_NBIT; i++) begin
            imem[i]      = {OP_ADDI, 10'd0, 16'(i)};  // addi to r0 changes no register.
            prog_used[i] = 1'b0;
        end
    endtask

    task automatic load_trace();
        int                      fd;
        int                      n;
        int                      want;
        int                      reg_num;
        logic [7:0]              kind;
        logic [IM_ADDR_NBIT-1:0] addr;
        logic [XLEN-1:0]         word;
        string                   rest;
        fd = $fopen(TRACE_PATH, "r");
        if (fd == 0) begin
            $display("cannot open the trace file %s", TRACE_PATH);
            stop_on_failure();
        end
        cycle_budget = 0;
        while ($fscanf(fd, " %c", kind) == 1) begin
            n    = 0;
            want = 0;
            case (kind)
                "P": begin
                    n               = $fscanf(fd, "%h %h", addr, word);
                    want            = 2;
                    imem[addr]      = word;
                    prog_used[addr] = 1'b1;
                end
                "W": begin
                    n    = $fscanf(fd, "%d %h", reg_num, word);
                    want = 2;
                    exp_reg.push_back(REG_NBIT'(reg_num));
                    exp_val.push_back(word);
                end
                "C": begin
                    n    = $fscanf(fd, "%d", cycle_budget);
                    want = 1;
                end
                "#": void'($fgets(rest, fd));  // the rest of the line is a comment.
                default: begin
                    $display("unknown line kind %c in %s", kind, TRACE_PATH);
                    stop_on_failure();
                end
            endcase
            if (n != want) begin
                $display("malformed %c line in %s", kind, TRACE_PATH);
                stop_on_failure();
            end
        end
        $fclose(fd);
        if (cycle_budget <= 0 || exp_reg.size() == 0) begin
            $display("%s gives no cycle budget or no expected writes", TRACE_PATH);
            stop_on_failure();
        end
    endtask

    // a stray fetch into the upper half lands on halt words.
    task automatic plant_halts();
        logic [IM_ADDR_NBIT-1:0] pick;
        for (int i = 0; i < HALT_PLANTS; i++) begin
            pick = {1'b1, HIGH_NBIT'($urandom)};
            if (!prog_used[pick]) begin
                imem[pick] = {OP_HALT, 26'(pick)};
            end
        end
    endtask

    always @(negedge clk) begin
        if (rst_n && wb_we) begin
            if (exp_idx >= exp_reg.size()) begin
                $display("register r%0d was written after the last expected write", wb_reg);
                stop_on_failure();
            end else begin
                check_value(XLEN'(wb_reg), XLEN'(exp_reg[exp_idx]),
                            $sformatf("register of write %0d", exp_idx));
                check_value(wb_data, exp_val[exp_idx], $sformatf("data of write %0d", exp_idx));
                exp_idx++;
            end
        end
    end

    initial begin
        int cycles;
        clk   = 1'b0;
        rst_n = 1'b0;
        void'($urandom(49));
        fill_imem();
        load_trace();
        plant_halts();
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        cycles = 0;
        while (!halted) begin
            @(negedge clk);
            cycles++;
            if (!halted && cycles >= cycle_budget) begin
                $display("timeout: the core did not halt within %0d cycles", cycle_budget);
                stop_on_failure();
            end
        end
        for (int i = 0; i < HOLD_CYCLES; i++) begin
            @(negedge clk);
            if (!halted) begin
                $display("halted dropped %0d cycles after it rose", i + 1);
                stop_on_failure();
            end
        end
        if (exp_idx != exp_reg.size()) begin
            $display("only %0d of %0d expected register writes were seen", exp_idx,
                     exp_reg.size());
            stop_on_failure();
        end else begin
            $display("ALL TESTS PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: verilog/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage
    import pipe_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  instr_t                  id_instr,
    input  logic [IM_ADDR_NBIT-1:0] id_pc,
    input  logic                    id_valid,
    input  logic [XLEN-1:0]         ra_data,
    input  logic [XLEN-1:0]         rb_data,
    input  logic [1:0]              id_fwd_a,
    input  logic [1:0]              id_fwd_b,
    input  logic [XLEN-1:0]         ex_result,
    input  logic [XLEN-1:0]         ma_result,
    input  logic                    idex_nop,
    output logic [REG_NBIT-1:0]     ra_idx,
    output logic [REG_NBIT-1:0]     rb_idx,
    output logic                    id_rf_ra,
    output logic                    id_rf_rb,
    output logic [REG_NBIT-1:0]     id_rf_req_a,
    output logic [REG_NBIT-1:0]     id_rf_req_b,
    output logic                    ex_valid,
    output logic [IM_ADDR_NBIT-1:0] ex_pc,
    output logic [5:0]              ex_op,
    output logic [5:0]              ex_funct,
    output logic [XLEN-1:0]         ex_a,
    output logic [XLEN-1:0]         ex_b,
    output logic [XLEN-1:0]         ex_imm,
    output logic                    ex_rf_we,
    output logic [REG_NBIT-1:0]     ex_rf_req_w,
    output logic                    ex_is_load,
    output logic                    ex_is_store,
    output logic                    ex_is_jump,
    output logic                    ex_is_branch,
    output logic                    ex_halt
);

    logic [5:0]          op;
    logic                uses_a, uses_b, writes;
    logic [REG_NBIT-1:0] dest;
    logic [XLEN-1:0]     imm, opnd_a, opnd_b;
    logic                hold;

    assign op          = id_instr.r_fmt.op;
    assign ra_idx      = id_instr.r_fmt.rs;
    assign rb_idx      = id_instr.r_fmt.rt;
    assign id_rf_req_a = ra_idx;
    assign id_rf_req_b = rb_idx;
    assign id_rf_ra    = id_valid && uses_a;
    assign id_rf_rb    = id_valid && uses_b;

    always_comb begin
        uses_a = 1'b0;
        uses_b = 1'b0;
        writes = 1'b0;
        dest   = id_instr.i_fmt.rt;
        imm    = {{(XLEN-16){id_instr.i_fmt.imm16[15]}}, id_instr.i_fmt.imm16};
        case (op)
            OP_RTYPE: begin
                uses_a = 1'b1;
                uses_b = 1'b1;
                writes = 1'b1;
                dest   = id_instr.r_fmt.rd;
            end
            OP_ADDI, OP_LW: begin
                uses_a = 1'b1;
                writes = 1'b1;
            end
            OP_SW, OP_BEQ, OP_BNE: begin
                uses_a = 1'b1;
                uses_b = 1'b1;
            end
            OP_J: imm = XLEN'(id_instr.j_fmt.target26);  // the jump target rides in imm.
            default: ;
        endcase
    end

    assign opnd_a = (id_fwd_a == FWD_TMP) ? ex_result :
                    (id_fwd_a == FWD_DAT) ? ma_result : ra_data;
    assign opnd_b = (id_fwd_b == FWD_TMP) ? ex_result :
                    (id_fwd_b == FWD_DAT) ? ma_result : rb_data;

    assign hold = ex_valid && ex_halt;  // a halt parks in EX until reset.

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_valid <= 1'b0;
        end else if (!hold) begin
            ex_valid <= id_valid && !idex_nop;
        end
    end

    always_ff @(posedge clk) begin
        if (!hold) begin
            ex_pc        <= id_pc;
            ex_op        <= op;
            ex_funct     <= id_instr.r_fmt.funct;
            ex_a         <= opnd_a;
            ex_b         <= opnd_b;
            ex_imm       <= imm;
            ex_rf_we     <= writes && dest != '0;
            ex_rf_req_w  <= dest;
            ex_is_load   <= op == OP_LW;
            ex_is_store  <= op == OP_SW;
            ex_is_jump   <= op == OP_J;
            ex_is_branch <= op == OP_BEQ || op == OP_BNE;
            ex_halt      <= op == OP_HALT;
        end
    end

endmodule

`default_nettype wire

// File: verilog/exec_stage.sv
`timescale 1ns/1ps
`default_nettype none

module exec_stage
    import pipe_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    ex_valid,
    input  logic [IM_ADDR_NBIT-1:0] ex_pc,
    input  logic [5:0]              ex_op,
    input  logic [5:0]              ex_funct,
    input  logic [XLEN-1:0]         ex_a,
    input  logic [XLEN-1:0]         ex_b,
    input  logic [XLEN-1:0]         ex_imm,
    input  logic                    ex_rf_we,
    input  logic [REG_NBIT-1:0]     ex_rf_req_w,
    input  logic                    ex_is_load,
    input  logic                    ex_is_store,
    input  logic                    ex_is_jump,
    input  logic                    ex_is_branch,
    input  logic                    ex_halt,
    output logic [XLEN-1:0]         ex_result,
    output logic                    ex_taken,
    output logic [IM_ADDR_NBIT-1:0] ex_target,
    output logic                    ma_valid,
    output logic                    ma_rf_we,
    output logic [REG_NBIT-1:0]     ma_rf_req_w,
    output logic                    ma_is_load,
    output logic                    ma_is_store,
    output logic [XLEN-1:0]         ma_addr,
    output logic [XLEN-1:0]         ma_store_data,
    output logic [XLEN-1:0]         ma_alu
);

    always_comb begin
        ex_result = ex_a + ex_imm;  // addi and the lw and sw address.
        if (ex_op == OP_RTYPE) begin
            case (ex_funct)
                FN_ADD:  ex_result = ex_a + ex_b;
                FN_SUB:  ex_result = ex_a - ex_b;
                FN_AND:  ex_result = ex_a & ex_b;
                FN_OR:   ex_result = ex_a | ex_b;
                FN_SLT:  ex_result = XLEN'($signed(ex_a) < $signed(ex_b));
                default: ex_result = ex_a + ex_b;
            endcase
        end
    end

    // beq takes on equal operands and bne on unequal ones.
    assign ex_taken  = ex_is_branch && ((ex_op == OP_BEQ) == (ex_a == ex_b));
    assign ex_target = ex_is_jump ? ex_imm[IM_ADDR_NBIT-1:0]
                                  : ex_pc + 1'b1 + ex_imm[IM_ADDR_NBIT-1:0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ma_valid <= 1'b0;
        end else begin
            ma_valid <= ex_valid && !ex_halt;  // halt never leaves EX.
        end
    end

    always_ff @(posedge clk) begin
        ma_rf_we      <= ex_rf_we;
        ma_rf_req_w   <= ex_rf_req_w;
        ma_is_load    <= ex_is_load;
        ma_is_store   <= ex_is_store;
        ma_addr       <= ex_result;
        ma_store_data <= ex_b;
        ma_alu        <= ex_result;
    end

endmodule

`default_nettype wire

// File: verilog/mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mem_stage
    import pipe_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                ma_valid,
    input  logic                ma_rf_we,
    input  logic [REG_NBIT-1:0] ma_rf_req_w,
    input  logic                ma_is_load,
    input  logic                ma_is_store,
    input  logic [XLEN-1:0]     ma_addr,
    input  logic [XLEN-1:0]     ma_store_data,
    input  logic [XLEN-1:0]     ma_alu,
    output logic [XLEN-1:0]     ma_result,
    output logic                wb_valid,
    output logic                wb_we,
    output logic [REG_NBIT-1:0] wb_reg,
    output logic [XLEN-1:0]     wb_data
);

    logic [XLEN-1:0]         dmem [2**DM_ADDR_NBIT];
    logic [DM_ADDR_NBIT-1:0] dm_idx;

    assign dm_idx    = ma_addr[DM_ADDR_NBIT-1:0];
    assign ma_result = ma_is_load ? dmem[dm_idx] : ma_alu;  // also the DAT forward.

    always_ff @(posedge clk) begin
        if (ma_valid && ma_is_store) begin
            dmem[dm_idx] <= ma_store_data;
        end
        wb_reg  <= ma_rf_req_w;
        wb_data <= ma_result;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
            wb_we    <= 1'b0;
        end else begin
            wb_valid <= ma_valid;
            wb_we    <= ma_valid && ma_rf_we;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        ma_valid && (ma_is_load || ma_is_store) |-> ma_addr[XLEN-1:DM_ADDR_NBIT] == '0)
        else $error("data memory address out of range: %h", ma_addr);

endmodule

`default_nettype wire

// File: verilog/pipe_core_top.sv
`timescale 1ns/1ps
`default_nettype none

module pipe_core_top
    import pipe_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    output logic [IM_ADDR_NBIT-1:0] imem_addr,
    input  logic [XLEN-1:0]         imem_data,
    output logic                    wb_we,
    output logic [REG_NBIT-1:0]     wb_reg,
    output logic [XLEN-1:0]         wb_data,
    output logic                    halted
);

    logic [IM_ADDR_NBIT-1:0] id_pc, ex_pc, ex_target, redirect_pc, bht_pc;
    instr_t                  id_instr;
    logic                    id_valid, id_rf_ra, id_rf_rb;
    logic [REG_NBIT-1:0]     ra_idx, rb_idx, id_rf_req_a, id_rf_req_b;
    logic [XLEN-1:0]         ra_data, rb_data;
    logic [1:0]              id_fwd_a, id_fwd_b, bht_op;
    logic                    ex_valid, ex_rf_we, ex_is_load, ex_is_store;
    logic                    ex_is_jump, ex_is_branch, ex_halt, ex_taken;
    logic [5:0]              ex_op, ex_funct;
    logic [XLEN-1:0]         ex_a, ex_b, ex_imm, ex_result;
    logic [REG_NBIT-1:0]     ex_rf_req_w, ma_rf_req_w;
    logic                    ma_valid, ma_rf_we, ma_is_load, ma_is_store, wb_valid;
    logic [XLEN-1:0]         ma_addr, ma_store_data, ma_alu, ma_result;
    logic                    pc_en, redirect, ifid_en, ifid_nop, idex_nop;

    fetch_unit fetch_unit_i (.*);

    decode_stage decode_stage_i (.*);

    reg_file reg_file_i (.*);

    exec_stage exec_stage_i (.*);

    mem_stage mem_stage_i (.*);

    hazard_ctrl hazard_ctrl_i (.*);

endmodule

`default_nettype wire

// File: verilog/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file
    import pipe_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic [REG_NBIT-1:0] ra_idx,
    input  logic [REG_NBIT-1:0] rb_idx,
    output logic [XLEN-1:0]     ra_data,
    output logic [XLEN-1:0]     rb_data,
    input  logic                wb_we,
    input  logic [REG_NBIT-1:0] wb_reg,
    input  logic [XLEN-1:0]     wb_data
);

    logic [XLEN-1:0] regs [2**REG_NBIT];

    // a register written this cycle reads back as the new value.
    assign ra_data = (ra_idx == '0) ? '0 :
                     (wb_we && wb_reg == ra_idx) ? wb_data : regs[ra_idx];
    assign rb_data = (rb_idx == '0) ? '0 :
                     (wb_we && wb_reg == rb_idx) ? wb_data : regs[rb_idx];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 2**REG_NBIT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_we && wb_reg != '0) begin
            regs[wb_reg] <= wb_data;
        end
    end

endmodule

`default_nettype wire
